/* Bender.yml */
package:
  name: mesh_route

sources:
  - files:
      - hw/mesh_route_pkg.sv
      - hw/mesh_addr_decode.sv
      - hw/xy_route_calc.sv
      - hw/next_router_addr_sel.sv
      - hw/look_ahead_route.sv
      - hw/mesh_route_unit.sv
  - target: test
    files:
      - test/mesh_route_checker.sv
      - test/mesh_route_tb.sv

/* hw/look_ahead_route.sv */
`timescale 1ns/1ps

module look_ahead_route (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           in_valid,
    input  logic [mesh_route_pkg::RXw-1:0] current_x,
    input  logic [mesh_route_pkg::RYw-1:0] current_y,
    input  logic [mesh_route_pkg::RXw-1:0] dest_x,
    input  logic [mesh_route_pkg::RYw-1:0] dest_y,
    input  logic [mesh_route_pkg::ELw-1:0] dest_l,
    input  mesh_route_pkg::port_t          destport,   // port chosen at this router
    input  logic                           addr_err,
    output logic                           out_valid,
    output mesh_route_pkg::port_t          destport_q,
    output mesh_route_pkg::port_t          lkdestport,
    output logic                           addr_err_q
);

    import mesh_route_pkg::*;

    logic [RXw-1:0] next_x;
    logic [RYw-1:0] next_y;
    port_t          next_port;    // XY port seen from the neighbor
    port_t          lk_port;

    next_router_addr_sel u_next_addr (
        .current_x (current_x),
        .current_y (current_y),
        .destport  (destport),
        .next_x    (next_x),
        .next_y    (next_y)
    );

    xy_route_calc u_next_route (
        .current_x (next_x),
        .current_y (next_y),
        .dest_x    (dest_x),
        .dest_y    (dest_y),
        .dest_l    (dest_l),
        .destport  (next_port)
    );

    // a packet leaving through a local port has no next router,
    // and an address error arrives here already forced to local0
    assign lk_port = is_local_port(destport) ? destport : next_port;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid  <= 1'b0;
            destport_q <= port_local0;
            lkdestport <= port_local0;
            addr_err_q <= 1'b0;
        end else begin
            out_valid <= in_valid;
            if (in_valid) begin                // idle cycles keep the last result
                destport_q <= destport;
                lkdestport <= lk_port;
                addr_err_q <= addr_err;
            end
        end
    end

endmodule

/* hw/mesh_addr_decode.sv */
`timescale 1ns/1ps

module mesh_addr_decode (
    input  logic [mesh_route_pkg::RAw-1:0] r_addr,  // current router
    input  logic [mesh_route_pkg::EAw-1:0] e_addr,  // destination endpoint
    output logic [mesh_route_pkg::RXw-1:0] rx,
    output logic [mesh_route_pkg::RYw-1:0] ry,
    output logic [mesh_route_pkg::RXw-1:0] ex,
    output logic [mesh_route_pkg::RYw-1:0] ey,
    output logic [mesh_route_pkg::ELw-1:0] el,
    output logic                           addr_err
);

    import mesh_route_pkg::*;

    logic [RAw-1:0] e_router;                // router part of the endpoint address
    logic           r_col_bad;
    logic           e_col_bad;

    // router address: row in the upper bits, column in the lower bits
    assign rx = r_addr[RXw-1:0];
    assign ry = r_addr[RAw-1 -: RYw];

    // endpoint address: local index sits above a router address
    assign e_router = e_addr[RAw-1:0];
    assign el       = e_addr[EAw-1 -: ELw];
    assign ex       = e_router[RXw-1:0];
    assign ey       = e_router[RAw-1 -: RYw];

    // column field can encode one value past the last column
    assign r_col_bad = (rx >= RXw'(NX));
    assign e_col_bad = (ex >= RXw'(NX));

    // rows fill their field exactly, so only the columns need a check
    assign addr_err = r_col_bad | e_col_bad;

endmodule

/* hw/mesh_route_pkg.sv */
package mesh_route_pkg;

    // mesh geometry
    localparam int NX = 3;             // columns
    localparam int NY = 4;             // rows
    localparam int NL = 2;             // endpoints per router

    // coordinate and address widths
    localparam int RXw = $clog2(NX);   // column coordinate
    localparam int RYw = $clog2(NY);   // row coordinate
    localparam int RAw = RXw + RYw;    // router address, row above column
    localparam int ELw = $clog2(NL);   // endpoint local index
    localparam int EAw = ELw + RAw;    // endpoint address, local index on top

    // router ports: two locals plus the four mesh directions
    localparam int P = 6;

    // east raises the column, south raises the row
    typedef enum logic [$clog2(P)-1:0] {
        port_local0 = 3'd0,
        port_local1 = 3'd1,
        port_east   = 3'd2,
        port_north  = 3'd3,
        port_west   = 3'd4,
        port_south  = 3'd5
    } port_t;

    // true for either endpoint port
    function automatic logic is_local_port(port_t port);
        logic res;
        res = (port == port_local0) || (port == port_local1);
        return res;
    endfunction

    // local port that serves endpoint index el
    function automatic port_t local_port(logic [ELw-1:0] el);
        port_t res;
        res = (el == ELw'(1)) ? port_local1 : port_local0;
        return res;
    endfunction

endpackage

/* hw/mesh_route_unit.sv */
`timescale 1ns/1ps

module mesh_route_unit (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           in_valid,
    input  logic [mesh_route_pkg::RAw-1:0] current_r_addr,
    input  logic [mesh_route_pkg::EAw-1:0] dest_e_addr,
    output logic                           out_valid,
    output mesh_route_pkg::port_t          destport,
    output mesh_route_pkg::port_t          lkdestport,
    output logic                           addr_err
);

    import mesh_route_pkg::*;

    logic [RXw-1:0] dec_rx;
    logic [RYw-1:0] dec_ry;
    logic [RXw-1:0] dec_ex;
    logic [RYw-1:0] dec_ey;
    logic [ELw-1:0] dec_el;
    logic           dec_err;
    port_t          xy_port;

    // stage 1 registers
    logic           s1_valid;
    logic [RXw-1:0] s1_rx;
    logic [RYw-1:0] s1_ry;
    logic [RXw-1:0] s1_ex;
    logic [RYw-1:0] s1_ey;
    logic [ELw-1:0] s1_el;
    port_t          s1_destport;
    logic           s1_err;

    mesh_addr_decode u_decode (
        .r_addr   (current_r_addr),
        .e_addr   (dest_e_addr),
        .rx       (dec_rx),
        .ry       (dec_ry),
        .ex       (dec_ex),
        .ey       (dec_ey),
        .el       (dec_el),
        .addr_err (dec_err)
    );

    xy_route_calc u_route (
        .current_x (dec_rx),
        .current_y (dec_ry),
        .dest_x    (dec_ex),
        .dest_y    (dec_ey),
        .dest_l    (dec_el),
        .destport  (xy_port)
    );

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            s1_valid    <= 1'b0;
            s1_destport <= port_local0;
            s1_err      <= 1'b0;
        end else begin
            s1_valid <= in_valid;
            if (in_valid) begin
                s1_destport <= dec_err ? port_local0 : xy_port;   // bad column reports local0
                s1_err      <= dec_err;
            end
        end
    end

    // coordinates only matter while s1_valid is high
    always_ff @(posedge clk) begin
        if (in_valid) begin
            s1_rx <= dec_rx;
            s1_ry <= dec_ry;
            s1_ex <= dec_ex;
            s1_ey <= dec_ey;
            s1_el <= dec_el;
        end
    end

    look_ahead_route u_look_ahead (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (s1_valid),
        .current_x  (s1_rx),
        .current_y  (s1_ry),
        .dest_x     (s1_ex),
        .dest_y     (s1_ey),
        .dest_l     (s1_el),
        .destport   (s1_destport),
        .addr_err   (s1_err),
        .out_valid  (out_valid),
        .destport_q (destport),
        .lkdestport (lkdestport),
        .addr_err_q (addr_err)
    );

endmodule

/* hw/next_router_addr_sel.sv */
`timescale 1ns/1ps

module next_router_addr_sel (
    input  logic [mesh_route_pkg::RXw-1:0] current_x,
    input  logic [mesh_route_pkg::RYw-1:0] current_y,
    input  mesh_route_pkg::port_t          destport,
    output logic [mesh_route_pkg::RXw-1:0] next_x,
    output logic [mesh_route_pkg::RYw-1:0] next_y
);

    import mesh_route_pkg::*;

    // on a mesh the neighbor is one step away, so no address table is needed
    always_comb begin
        next_x = current_x;
        next_y = current_y;
        case (destport)
            port_east: begin
                next_x = current_x + RXw'(1);
            end
            port_west: begin
                next_x = current_x - RXw'(1);
            end
            port_south: begin
                next_y = current_y + RYw'(1);
            end
            port_north: begin
                next_y = current_y - RYw'(1);
            end
            default: begin
                // local ports stay on this router
            end
        endcase
    end

endmodule

/* hw/xy_route_calc.sv */
`timescale 1ns/1ps

module xy_route_calc (
    input  logic [mesh_route_pkg::RXw-1:0] current_x,
    input  logic [mesh_route_pkg::RYw-1:0] current_y,
    input  logic [mesh_route_pkg::RXw-1:0] dest_x,
    input  logic [mesh_route_pkg::RYw-1:0] dest_y,
    input  logic [mesh_route_pkg::ELw-1:0] dest_l,   // endpoint index at the destination
    output mesh_route_pkg::port_t          destport
);

    import mesh_route_pkg::*;

    logic go_east;
    logic go_west;
    logic go_south;
    logic go_north;

    assign go_east  = dest_x > current_x;
    assign go_west  = dest_x < current_x;
    assign go_south = dest_y > current_y;    // rows grow downward
    assign go_north = dest_y < current_y;

    // x dimension is resolved completely before any y hop is taken,
    // which keeps the routing deadlock free on a mesh
    always_comb begin
        if (go_east) begin
            destport = port_east;
        end else if (go_west) begin
            destport = port_west;
        end else if (go_south) begin
            destport = port_south;
        end else if (go_north) begin
            destport = port_north;
        end else begin
            destport = local_port(dest_l);    // arrived, eject to the endpoint
        end
    end

endmodule

/* mesh_route.f */
hw/mesh_route_pkg.sv
hw/mesh_addr_decode.sv
hw/xy_route_calc.sv
hw/next_router_addr_sel.sv
hw/look_ahead_route.sv
hw/mesh_route_unit.sv
test/mesh_route_checker.sv
test/mesh_route_tb.sv

/* test/mesh_route_checker.sv */
`timescale 1ns/1ps

module mesh_route_checker (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  in_valid,
    input  logic                  out_valid,
    input  mesh_route_pkg::port_t destport,
    input  mesh_route_pkg::port_t lkdestport,
    input  logic                  addr_err,
    output int                    n_checked,
    output int                    n_errors
);

    import mesh_route_pkg::*;

    typedef struct packed {
        logic [RAw-1:0] r_addr;
        logic [EAw-1:0] e_addr;
        port_t          dport;
        port_t          lkport;
        logic           err;
    } vec_t;

    vec_t       expect_q[$];      // expected results in request order
    logic [1:0] valid_hist;       // in_valid at the last two edges
    logic       after_reset;

    initial begin
        int    fd;
        int    r;
        int    e;
        int    d;
        int    lk;
        int    err;
        string line;
        vec_t  v;
        fd = $fopen("test/mesh_route_testdata.txt", "r");
        if (fd == 0) begin
            $display("checker could not open test/mesh_route_testdata.txt");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() > 0 && line[0] != "#") begin
                    if ($sscanf(line, "%h %h %d %d %d", r, e, d, lk, err) == 5) begin
                        v.r_addr = r[RAw-1:0];
                        v.e_addr = e[EAw-1:0];
                        v.dport  = port_t'(d[2:0]);
                        v.lkport = port_t'(lk[2:0]);
                        v.err    = err[0];
                        expect_q.push_back(v);
                    end
                end
            end
            $fclose(fd);
        end
    end

    always @(posedge clk) begin
        vec_t exp_v;
        if (!rst_n) begin
            valid_hist  <= 2'b00;
            after_reset <= 1'b1;
        end else begin
            valid_hist  <= {valid_hist[0], in_valid};
            after_reset <= 1'b0;
            if (after_reset && (out_valid !== 1'b0 || destport !== port_local0)) begin
                $display("error at %0t: out_valid or destport not cleared by reset", $time);
                n_errors++;
            end
            // a request sampled two edges ago must show up now
            if (out_valid !== valid_hist[1]) begin
                $display("error at %0t: out_valid is %b but in_valid two cycles earlier was %b",
                         $time, out_valid, valid_hist[1]);
                n_errors++;
            end
            if (out_valid === 1'b1) begin
                if (expect_q.size() == 0) begin
                    $display("a result came out at %0t with no request outstanding", $time);
                    n_errors++;
                end else begin
                    exp_v = expect_q.pop_front();
                    if (destport !== exp_v.dport || lkdestport !== exp_v.lkport ||
                        addr_err !== exp_v.err) begin
                        $display("error at %0t: vector %0d r=%h e=%h got %s/%s/%b expected %s/%s/%b",
                                 $time, n_checked, exp_v.r_addr, exp_v.e_addr,
                                 destport.name(), lkdestport.name(), addr_err,
                                 exp_v.dport.name(), exp_v.lkport.name(), exp_v.err);
                        n_errors++;
                    end else begin
                        $display("vector %0d r=%h e=%h %s/%s err=%b ok", n_checked,
                                 exp_v.r_addr, exp_v.e_addr, destport.name(),
                                 lkdestport.name(), addr_err);
                    end
                    n_checked++;
                end
            end
        end
    end

endmodule

/* test/mesh_route_tb.sv */
`timescale 1ns/1ps

module mesh_route_tb;

    import mesh_route_pkg::*;

    localparam int MAX_VEC     = 64;
    localparam int DRAIN_LIMIT = 200;    // cycles allowed for the last results

    logic           clk;
    logic           rst_n;
    logic           in_valid;
    logic [RAw-1:0] current_r_addr;
    logic [EAw-1:0] dest_e_addr;
    logic           out_valid;
    port_t          destport;
    port_t          lkdestport;
    logic           addr_err;
    int             n_checked;
    int             n_errors;

    logic [RAw-1:0] r_vec [MAX_VEC];
    logic [EAw-1:0] e_vec [MAX_VEC];
    int             n_vec;
    int             seed;
    bit             timed_out;

    mesh_route_unit dut (
        .clk            (clk),
        .rst_n          (rst_n),
        .in_valid       (in_valid),
        .current_r_addr (current_r_addr),
        .dest_e_addr    (dest_e_addr),
        .out_valid      (out_valid),
        .destport       (destport),
        .lkdestport     (lkdestport),
        .addr_err       (addr_err)
    );

    mesh_route_checker u_checker (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .out_valid  (out_valid),
        .destport   (destport),
        .lkdestport (lkdestport),
        .addr_err   (addr_err),
        .n_checked  (n_checked),
        .n_errors   (n_errors)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial begin
        int    fd;
        int    gap;
        int    wait_cycles;
        int    r;
        int    e;
        int    d;
        int    lk;
        int    err;
        string line;
        rst_n          = 1'b0;
        in_valid       = 1'b0;
        current_r_addr = '0;
        dest_e_addr    = '0;
        seed           = 32'h020f_4468;
        n_vec          = 0;
        timed_out      = 1'b0;
        fd = $fopen("test/mesh_route_testdata.txt", "r");
        if (fd == 0) begin
            $display("could not open test/mesh_route_testdata.txt");
        end else begin
            while (!$feof(fd) && n_vec < MAX_VEC) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() > 0 && line[0] != "#") begin
                    if ($sscanf(line, "%h %h %d %d %d", r, e, d, lk, err) == 5) begin
                        r_vec[n_vec] = r[RAw-1:0];
                        e_vec[n_vec] = e[EAw-1:0];
                        n_vec++;
                    end
                end
            end
            $fclose(fd);
        end
        repeat (3) @(posedge clk);    // three reset edges
        @(negedge clk);
        rst_n = 1'b1;
        for (int i = 0; i < n_vec; i++) begin
            @(negedge clk);
            in_valid       = 1'b1;
            current_r_addr = r_vec[i];
            dest_e_addr    = e_vec[i];
            gap = $unsigned($random(seed)) % 3;    // zero sends the next one back to back
            repeat (gap) begin
                @(negedge clk);
                in_valid = 1'b0;
            end
        end
        @(negedge clk);
        in_valid    = 1'b0;
        wait_cycles = 0;
        while (n_checked < n_vec && wait_cycles < DRAIN_LIMIT) begin
            @(negedge clk);
            wait_cycles++;
        end
        if (n_checked < n_vec) begin
            $display("timeout waiting for results, %0d of %0d arrived", n_checked, n_vec);
            timed_out = 1'b1;
        end
        repeat (4) @(negedge clk);    // catch a stray out_valid
        $display("checked %0d vectors, %0d errors", n_checked, n_errors);
        if (timed_out || n_errors != 0 || n_vec == 0) begin
            $display("CHECKS FAILED");
        end else begin
            $display("ALL CHECKS PASSED");
        end
        $finish;
    end

endmodule

/* test/mesh_route_testdata.txt */
# r_addr(hex) e_addr(hex) destport lkdestport addr_err
# ports: 0 local0, 1 local1, 2 east, 3 north, 4 west, 5 south
0 02 2 2 0
0 11 2 1 0
6 04 4 4 0
9 18 4 1 0
1 0d 5 5 0
9 0d 5 0 0
e 12 3 3 0
4 00 3 0 0
5 05 0 0 0
5 15 1 1 0
e 1e 1 1 0
0 09 2 5 0
e 11 4 3 0
c 05 2 3 0
2 1d 4 5 0
8 0e 2 2 0
d 11 3 3 0
3 00 0 0 1
5 1b 0 0 1
f 0f 0 0 1
8 07 0 0 1
a 10 4 4 0
6 1a 5 1 0
d 00 4 3 0
0 1c 5 5 0
a 06 3 0 0
